/* src/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry, direct mapped
`define DC_LINES 16
`define DC_LINE_BYTES 16

// backing store, addresses above this alias
`define MEM_BYTES 4096

// cycles from transfer acceptance to mem_done
`define MEM_LATENCY 4

`endif

/* src/mem_op_pkg.sv */
package mem_op_pkg;

    // pipeline memory operation kinds
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } mem_op_e;

    // access width in bytes
    function automatic logic [2:0] op_bytes(mem_op_e op);
        case (op)
            LB, LBU, SB: return 3'd1;
            LH, LHU, SH: return 3'd2;
            default:     return 3'd4;
        endcase
    endfunction

    function automatic logic is_store(mem_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

/* src/dcache_pkg.sv */
`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`DC_LINE_BYTES*8-1:0] line_t;

    // address split: tag 31..8, index 7..4, offset 3..0
    typedef logic [23:0] tag_t;
    typedef logic [3:0]  index_t;
    typedef logic [3:0]  offset_t;

    // controller states
    // LOOKUP checks the array, WRITEBACK evicts a dirty line,
    // REFILL fetches the missing line, FILL writes it back into the array
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL
    } ctrl_state_e;

endpackage

/* src/refill_if.sv */
`timescale 1ns/1ns

interface refill_if;

    // controller to memory
    logic               mem_req;
    logic               mem_we;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::line_t  mem_wline;

    // memory to controller
    logic               mem_ready;
    logic               mem_done;
    dcache_pkg::line_t  mem_rline;

    modport ctrl (
        output mem_req, mem_we, mem_addr, mem_wline,
        input  mem_ready, mem_done, mem_rline
    );

    modport mem (
        input  mem_req, mem_we, mem_addr, mem_wline,
        output mem_ready, mem_done, mem_rline
    );

endinterface

/* src/dcache_array.sv */
`timescale 1ns/1ns

`include "dcache_params.svh"

module dcache_array (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  dcache_pkg::index_t           index_i,
    input  dcache_pkg::tag_t             tag_i,
    input  logic                         fill_i,
    input  dcache_pkg::line_t            fill_line_i,
    input  logic                         store_i,
    input  logic [`DC_LINE_BYTES-1:0]    store_be_i,
    input  dcache_pkg::line_t            store_line_i,
    output logic                         hit_o,
    output logic                         dirty_o,
    output dcache_pkg::tag_t             victim_tag_o,
    output dcache_pkg::line_t            line_o
);

    logic [`DC_LINES-1:0] valid_q;
    logic [`DC_LINES-1:0] dirty_q;
    dcache_pkg::tag_t     tag_q  [`DC_LINES];
    dcache_pkg::line_t    data_q [`DC_LINES];

    dcache_pkg::line_t    merged_line;

    // lookup
    assign hit_o        = valid_q[index_i] && (tag_q[index_i] == tag_i);
    assign dirty_o      = valid_q[index_i] && dirty_q[index_i];
    assign victim_tag_o = tag_q[index_i];
    assign line_o       = data_q[index_i];

    // fill replaces the line first, a store then lands on top of it
    always_comb begin
        merged_line = fill_i ? fill_line_i : data_q[index_i];
        if (store_i) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (store_be_i[b]) begin
                    merged_line[b*8 +: 8] = store_line_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= store_i;
            end else if (store_i) begin
                dirty_q[index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[index_i] <= tag_i;
        end
        if (fill_i || store_i) begin
            data_q[index_i] <= merged_line;
        end
    end

endmodule

/* src/load_store_align.sv */
`timescale 1ns/1ns

`include "dcache_params.svh"

module load_store_align (
    input  mem_op_pkg::mem_op_e          op_i,
    input  dcache_pkg::offset_t          offset_i,
    input  dcache_pkg::line_t            line_i,
    input  dcache_pkg::word_t            wdata_i,
    output dcache_pkg::word_t            load_data_o,
    output logic [`DC_LINE_BYTES-1:0]    store_be_o,
    output dcache_pkg::line_t            store_line_o
);

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    dcache_pkg::word_t word_sel;
    logic [2:0]        nbytes;

    // aligned lanes only, so the low offset bits are ignored for wider accesses
    assign byte_sel = line_i[{offset_i, 3'b000} +: 8];
    assign half_sel = line_i[{offset_i[3:1], 4'b0000} +: 16];
    assign word_sel = line_i[{offset_i[3:2], 5'b00000} +: 32];

    always_comb begin
        case (op_i)
            mem_op_pkg::LB:  load_data_o = {{24{byte_sel[7]}}, byte_sel};
            mem_op_pkg::LBU: load_data_o = {24'd0, byte_sel};
            mem_op_pkg::LH:  load_data_o = {{16{half_sel[15]}}, half_sel};
            mem_op_pkg::LHU: load_data_o = {16'd0, half_sel};
            mem_op_pkg::LW:  load_data_o = word_sel;
            // stores answer with zero
            default:         load_data_o = '0;
        endcase
    end

    assign nbytes = mem_op_pkg::op_bytes(op_i);

    // byte enables start at the aligned offset
    assign store_be_o = mem_op_pkg::is_store(op_i) ?
        (`DC_LINE_BYTES'((1 << nbytes) - 1) << offset_i) : '0;

    // data copied to every lane, the enables pick the right one
    always_comb begin
        case (nbytes)
            3'd1:    store_line_o = {`DC_LINE_BYTES{wdata_i[7:0]}};
            3'd2:    store_line_o = {(`DC_LINE_BYTES/2){wdata_i[15:0]}};
            default: store_line_o = {(`DC_LINE_BYTES/4){wdata_i}};
        endcase
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   req_valid_i,
    input  mem_op_pkg::mem_op_e    req_op_i,
    input  dcache_pkg::addr_t      req_addr_i,
    input  dcache_pkg::word_t      req_wdata_i,
    input  logic                   hit_i,
    input  logic                   dirty_i,
    input  dcache_pkg::tag_t       victim_tag_i,
    input  dcache_pkg::line_t      line_i,
    input  dcache_pkg::word_t      load_data_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output dcache_pkg::word_t      rsp_data_o,
    output dcache_pkg::index_t     index_o,
    output dcache_pkg::tag_t       tag_o,
    output mem_op_pkg::mem_op_e    op_o,
    output dcache_pkg::offset_t    offset_o,
    output dcache_pkg::word_t      wdata_o,
    output logic                   fill_o,
    output dcache_pkg::line_t      fill_line_o,
    output logic                   store_o,
    refill_if.ctrl                 mem
);

    dcache_pkg::ctrl_state_e state_q;

    // captured request
    mem_op_pkg::mem_op_e     op_q;
    dcache_pkg::addr_t       addr_q;
    dcache_pkg::word_t       wdata_q;

    logic                    sent_q;
    dcache_pkg::line_t       refill_q;
    logic                    rsp_valid_q;
    dcache_pkg::word_t       rsp_data_q;

    logic                    accept;
    logic                    respond;
    logic                    in_xfer;

    assign req_ready_o = (state_q == dcache_pkg::IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign respond     = (state_q == dcache_pkg::LOOKUP && hit_i) ||
                         (state_q == dcache_pkg::FILL);
    assign in_xfer     = (state_q == dcache_pkg::WRITEBACK) ||
                         (state_q == dcache_pkg::REFILL);

    assign index_o  = addr_q[7:4];
    assign tag_o    = addr_q[31:8];
    assign offset_o = addr_q[3:0];
    assign op_o     = op_q;
    assign wdata_o  = wdata_q;

    // array writes
    assign fill_o  = (state_q == dcache_pkg::FILL);
    assign store_o = respond && mem_op_pkg::is_store(op_q);

    // also the aligner's line, the refilled line during FILL
    assign fill_line_o = fill_o ? refill_q : line_i;

    // memory side, request drops once accepted
    assign mem.mem_req   = in_xfer && !sent_q;
    assign mem.mem_we    = (state_q == dcache_pkg::WRITEBACK);
    assign mem.mem_addr  = mem.mem_we ? {victim_tag_i, index_o, 4'b0000} :
                                        {addr_q[31:4], 4'b0000};
    assign mem.mem_wline = line_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= dcache_pkg::IDLE;
            sent_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= respond;
            case (state_q)
                dcache_pkg::IDLE: begin
                    if (accept) begin
                        state_q <= dcache_pkg::LOOKUP;
                    end
                end
                dcache_pkg::LOOKUP: begin
                    if (hit_i) begin
                        state_q <= dcache_pkg::IDLE;
                    end else if (dirty_i) begin
                        state_q <= dcache_pkg::WRITEBACK;
                    end else begin
                        state_q <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::WRITEBACK, dcache_pkg::REFILL: begin
                    if (mem.mem_req && mem.mem_ready) begin
                        sent_q <= 1'b1;
                    end
                    if (sent_q && mem.mem_done) begin
                        sent_q  <= 1'b0;
                        state_q <= (state_q == dcache_pkg::WRITEBACK) ?
                                   dcache_pkg::REFILL : dcache_pkg::FILL;
                    end
                end
                dcache_pkg::FILL: begin
                    state_q <= dcache_pkg::IDLE;
                end
                default: begin
                    state_q <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
        if (state_q == dcache_pkg::REFILL && sent_q && mem.mem_done) begin
            refill_q <= mem.mem_rline;
        end
        // aligner already gives zero for stores
        if (respond) begin
            rsp_data_q <= load_data_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;

endmodule

/* src/main_mem_ctrl.sv */
`timescale 1ns/1ns

`include "dcache_params.svh"

module main_mem_ctrl (
    input  logic   clk_i,
    input  logic   rst_i,
    refill_if.mem  mem
);

    localparam int MEM_LINES = `MEM_BYTES / `DC_LINE_BYTES;
    localparam int LINE_AW   = $clog2(MEM_LINES);
    localparam int OFS_W     = $clog2(`DC_LINE_BYTES);
    localparam int CNT_W     = $clog2(`MEM_LATENCY + 1);

    dcache_pkg::line_t    mem_q [MEM_LINES];

    logic                 busy_q;
    logic                 done_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 we_q;
    logic [LINE_AW-1:0]   line_idx_q;
    dcache_pkg::line_t    wline_q;
    dcache_pkg::line_t    rline_q;

    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            mem_q[i] = '0;
        end
    end

    // stays low through the done pulse
    assign mem.mem_ready = !busy_q && !done_q;
    assign mem.mem_done  = done_q;
    assign mem.mem_rline = rline_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (mem.mem_req && mem.mem_ready) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    // latch the transfer, then perform it when the count runs out
    always_ff @(posedge clk_i) begin
        if (mem.mem_req && mem.mem_ready) begin
            we_q       <= mem.mem_we;
            line_idx_q <= mem.mem_addr[OFS_W +: LINE_AW];
            wline_q    <= mem.mem_wline;
        end
        if (busy_q && cnt_q == '0) begin
            if (we_q) begin
                mem_q[line_idx_q] <= wline_q;
            end
            rline_q <= mem_q[line_idx_q];
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ns

`include "dcache_params.svh"

module dcache_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  mem_op_pkg::mem_op_e   req_op_i,
    input  dcache_pkg::addr_t     req_addr_i,
    input  dcache_pkg::word_t     req_wdata_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,
    output dcache_pkg::word_t     rsp_data_o
);

    // controller to array and aligner
    dcache_pkg::index_t           index;
    dcache_pkg::tag_t             tag;
    mem_op_pkg::mem_op_e          op;
    dcache_pkg::offset_t          offset;
    dcache_pkg::word_t            wdata;
    logic                         fill;
    dcache_pkg::line_t            fill_line;
    logic                         store;

    // array and aligner back to controller
    logic                         hit;
    logic                         dirty;
    dcache_pkg::tag_t             victim_tag;
    dcache_pkg::line_t            line;
    dcache_pkg::word_t            load_data;
    logic [`DC_LINE_BYTES-1:0]    store_be;
    dcache_pkg::line_t            store_line;

    refill_if mem_bus ();

    dcache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .hit_i        (hit),
        .dirty_i      (dirty),
        .victim_tag_i (victim_tag),
        .line_i       (line),
        .load_data_i  (load_data),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_data_o   (rsp_data_o),
        .index_o      (index),
        .tag_o        (tag),
        .op_o         (op),
        .offset_o     (offset),
        .wdata_o      (wdata),
        .fill_o       (fill),
        .fill_line_o  (fill_line),
        .store_o      (store),
        .mem          (mem_bus.ctrl)
    );

    dcache_array u_array (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (index),
        .tag_i        (tag),
        .fill_i       (fill),
        .fill_line_i  (fill_line),
        .store_i      (store),
        .store_be_i   (store_be),
        .store_line_i (store_line),
        .hit_o        (hit),
        .dirty_o      (dirty),
        .victim_tag_o (victim_tag),
        .line_o       (line)
    );

    // aligner sees the refilled line during FILL
    load_store_align u_align (
        .op_i         (op),
        .offset_i     (offset),
        .line_i       (fill_line),
        .wdata_i      (wdata),
        .load_data_o  (load_data),
        .store_be_o   (store_be),
        .store_line_o (store_line)
    );

    main_mem_ctrl u_mem (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem          (mem_bus.mem)
    );

endmodule

/* testbench/dcache_chk.sv */
`timescale 1ns/1ns

module dcache_chk (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_valid_i,
    input  logic               req_ready_i,
    input  logic               rsp_valid_i,
    input  logic               mem_req_i,
    input  logic               mem_ready_i,
    input  logic               mem_we_i,
    input  dcache_pkg::addr_t  mem_addr_i,
    input  dcache_pkg::line_t  mem_wline_i
);

    // set by an accepted request, cleared by its response
    logic pending_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            pending_q <= 1'b1;
        end else if (rsp_valid_i) begin
            pending_q <= 1'b0;
        end
    end

    // memory request and its fields hold until accepted
    mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i && !mem_ready_i |=> mem_req_i && $stable(mem_we_i) &&
        $stable(mem_addr_i) && $stable(mem_wline_i))
        else $error("memory request changed before it was accepted");

    rsp_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_i |=> !rsp_valid_i)
        else $error("response valid lasted more than one cycle");

    rsp_needs_request: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_i |-> pending_q)
        else $error("response without an accepted request");

    // no new request while one is still in flight
    ready_low_when_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        pending_q && !rsp_valid_i |-> !req_ready_i)
        else $error("request port ready while a request is outstanding");

endmodule

bind dcache_ctrl dcache_chk u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .mem_req_i   (mem.mem_req),
    .mem_ready_i (mem.mem_ready),
    .mem_we_i    (mem.mem_we),
    .mem_addr_i  (mem.mem_addr),
    .mem_wline_i (mem.mem_wline)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/1ns

`include "dcache_params.svh"

module dcache_tb;

    localparam int TIMEOUT_CYCLES = 200;

    logic                 clk_i;
    logic                 rst_i;
    logic                 req_valid_i;
    mem_op_pkg::mem_op_e  req_op_i;
    dcache_pkg::addr_t    req_addr_i;
    dcache_pkg::word_t    req_wdata_i;
    logic                 req_ready_o;
    logic                 rsp_valid_o;
    dcache_pkg::word_t    rsp_data_o;

    // byte image of main memory, little endian
    logic [7:0] model_mem [`MEM_BYTES];

    dcache_top UUT (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %08h actual %08h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("TEST FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic logic writes_memory(input mem_op_pkg::mem_op_e op);
        return op == mem_op_pkg::SB || op == mem_op_pkg::SH || op == mem_op_pkg::SW;
    endfunction

    // sign or zero extension of the bytes at addr
    function automatic logic [31:0] expected_load(input mem_op_pkg::mem_op_e op,
                                                  input logic [31:0] addr);
        logic [11:0] a;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        a  = addr[11:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 12'd1];
        b2 = model_mem[a + 12'd2];
        b3 = model_mem[a + 12'd3];
        case (op)
            mem_op_pkg::LB:  return {{24{b0[7]}}, b0};
            mem_op_pkg::LBU: return {24'd0, b0};
            mem_op_pkg::LH:  return {{16{b1[7]}}, b1, b0};
            mem_op_pkg::LHU: return {16'd0, b1, b0};
            mem_op_pkg::LW:  return {b3, b2, b1, b0};
            default:         return 32'd0;
        endcase
    endfunction

    function automatic void apply_store(input mem_op_pkg::mem_op_e op,
                                        input logic [31:0] addr, input logic [31:0] wdata);
        logic [11:0] a;
        a = addr[11:0];
        model_mem[a] = wdata[7:0];
        if (op != mem_op_pkg::SB) begin
            model_mem[a + 12'd1] = wdata[15:8];
        end
        if (op == mem_op_pkg::SW) begin
            model_mem[a + 12'd2] = wdata[23:16];
            model_mem[a + 12'd3] = wdata[31:24];
        end
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic run_access(input mem_op_pkg::mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output int lat);
        int waited;
        waited = 0;
        while (!req_ready_o) begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_on_timeout("req_ready_o");
            end
        end
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        lat = 0;
        do begin
            @(posedge clk_i);
            #1;
            // taken at the first edge
            req_valid_i = 1'b0;
            lat++;
            if (lat > TIMEOUT_CYCLES) begin
                abort_on_timeout("rsp_valid_o");
            end
        end while (!rsp_valid_o);
        data = rsp_data_o;
    endtask

    task automatic issue_and_check(input string name, input mem_op_pkg::mem_op_e op,
                                   input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] expected;
        logic [31:0] actual;
        int          lat;
        expected = writes_memory(op) ? 32'd0 : expected_load(op, addr);
        run_access(op, addr, wdata, actual, lat);
        check_value(name, expected, actual);
        if (writes_memory(op)) begin
            apply_store(op, addr, wdata);
        end
    endtask

    // every load kind at every aligned offset of one line
    task automatic read_back_line(input string name, input logic [31:0] base);
        for (int ofs = 0; ofs < `DC_LINE_BYTES; ofs++) begin
            issue_and_check($sformatf("%s lb +%0d", name, ofs), mem_op_pkg::LB, base + ofs, 0);
            issue_and_check($sformatf("%s lbu +%0d", name, ofs), mem_op_pkg::LBU, base + ofs, 0);
            if (ofs % 2 == 0) begin
                issue_and_check($sformatf("%s lh +%0d", name, ofs), mem_op_pkg::LH,
                                base + ofs, 0);
                issue_and_check($sformatf("%s lhu +%0d", name, ofs), mem_op_pkg::LHU,
                                base + ofs, 0);
            end
            if (ofs % 4 == 0) begin
                issue_and_check($sformatf("%s lw +%0d", name, ofs), mem_op_pkg::LW,
                                base + ofs, 0);
            end
        end
    endtask

    initial begin
        mem_op_pkg::mem_op_e op;
        logic [31:0]         addr;
        logic [31:0]         wdata;
        logic [31:0]         data;
        int                  lat;

        clk_i       = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = mem_op_pkg::LW;
        req_addr_i  = '0;
        req_wdata_i = '0;
        void'($urandom(32'h0eff_f3ba));
        for (int i = 0; i < `MEM_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end

        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value("reset req_ready_o", 32'd1, 32'(req_ready_o));
        check_value("reset rsp_valid_o", 32'd0, 32'(rsp_valid_o));

        // park a nonzero word in memory through a dirty eviction
        issue_and_check("seed sw", mem_op_pkg::SW, 32'h0000_0040, 32'hc3a5_9e17);
        issue_and_check("seed evict", mem_op_pkg::LW, 32'h0000_0140, 0);

        // miss then hit on the same word
        issue_and_check("first load", mem_op_pkg::LW, 32'h0000_0040, 0);
        run_access(mem_op_pkg::LW, 32'h0000_0040, 0, data, lat);
        check_value("hit data", expected_load(mem_op_pkg::LW, 32'h0000_0040), data);
        check_value("hit latency", 32'd2, 32'(lat));

        // bytes 80, 91, a2 ... with the sign bit set in the lower eight
        for (int w = 0; w < 4; w++) begin
            wdata = '0;
            for (int b = 0; b < 4; b++) begin
                wdata[b*8 +: 8] = 8'h80 + 8'h11 * (w * 4 + b);
            end
            issue_and_check($sformatf("pattern sw %0d", w), mem_op_pkg::SW,
                            32'h0000_0200 + 4 * w, wdata);
        end
        read_back_line("pattern", 32'h0000_0200);

        // mixed widths merged into one line
        issue_and_check("merge sw", mem_op_pkg::SW, 32'h0000_0300, 32'hdead_beef);
        issue_and_check("merge sh", mem_op_pkg::SH, 32'h0000_0306, 32'h0000_8a5c);
        issue_and_check("merge sb", mem_op_pkg::SB, 32'h0000_0309, 32'h0000_00f0);
        issue_and_check("merge sh hi", mem_op_pkg::SH, 32'h0000_030c, 32'h1234_c7e1);
        issue_and_check("merge sb hi", mem_op_pkg::SB, 32'h0000_030f, 32'h0000_007e);
        read_back_line("merge", 32'h0000_0300);

        // same index, 256 bytes apart, forces a dirty eviction
        issue_and_check("evict sw", mem_op_pkg::SW, 32'h0000_0480, 32'h1234_5678);
        issue_and_check("evict other", mem_op_pkg::LW, 32'h0000_0580, 0);
        issue_and_check("evict reload", mem_op_pkg::LW, 32'h0000_0480, 0);
        issue_and_check("evict reload byte", mem_op_pkg::LBU, 32'h0000_0483, 0);

        // random traffic over 1 KiB, four tags per index
        for (int i = 0; i < 2000; i++) begin
            op    = mem_op_pkg::mem_op_e'($urandom_range(7, 0));
            addr  = 32'h0000_0800 | ($urandom & 32'h0000_03ff);
            wdata = $urandom;
            case (op)
                mem_op_pkg::LH, mem_op_pkg::LHU, mem_op_pkg::SH: addr[0] = 1'b0;
                mem_op_pkg::LW, mem_op_pkg::SW: addr[1:0] = 2'b00;
                default: ;
            endcase
            issue_and_check($sformatf("random %0d", i), op, addr, wdata);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/mem_op_pkg.sv
src/dcache_pkg.sv
src/refill_if.sv
src/dcache_array.sv
src/load_store_align.sv
src/dcache_ctrl.sv
src/main_mem_ctrl.sv
src/dcache_top.sv
testbench/dcache_chk.sv
testbench/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the dcache simulation with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dcache_tb -f tb.f -o dcache_sim

# a $fatal or a failed assertion ends the run with a nonzero status
./obj_dir/dcache_sim
